/* src.f */
+incdir+tests
verilog/fpu_pkg.sv
verilog/fpu_ftoi.sv
verilog/fpu_itof.sv
verilog/fpu_floor.sv
verilog/fpu_result_select.sv
verilog/fpu_top.sv
tests/fpu_chk.sv
tests/fpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= fpu_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --assert -j 0

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$($(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* tests/fpu_model.svh */
`ifndef FPU_MODEL_SVH
`define FPU_MODEL_SVH

// signed integer to single, nearest even
function automatic fp32_t model_itof(int32_t v);
	longint mag;
	longint sig;
	longint rest;
	longint half;
	int     p;
	int     sh;
	mag = longint'($signed(v));
	if (mag < 0) mag = -mag;
	if (mag == 0) return '0;
	p = 0;
	while ((mag >> (p + 1)) != 0) p++;	// leading one position
	if (p <= 23) begin
		sig = mag << (23 - p);
	end else begin
		sh   = p - 23;
		sig  = mag >> sh;
		rest = mag - (sig << sh);
		half = longint'(1) << (sh - 1);
		if (rest > half || (rest == half && sig[0])) sig++;
		if (sig == (longint'(1) << 24)) begin
			sig = sig >> 1;
			p++;
		end
	end
	return {v[31], 8'(p + 127), sig[22:0]};
endfunction

// single to signed integer, half away from zero
function automatic int32_t model_ftoi(fp32_t x, output fpu_exc_t flags);
	int     e;
	longint m;
	longint mag;
	flags = '0;
	e = int'(x[30:23]);
	m = longint'({1'b1, x[22:0]});
	if (e == 255 && x[22:0] != 0) begin
		flags.nan = 1'b1;
		return '0;
	end
	if (e > 158) begin
		flags.ovf = 1'b1;
		return '0;
	end
	if (e < 126) return '0;
	if (e >= 150) mag = m << (e - 150);
	else mag = (m >> (150 - e)) + ((m >> (149 - e)) & 1);	// plus the half bit
	if (mag > (longint'(1) << 31) || (mag == (longint'(1) << 31) && !x[31])) begin
		flags.ovf = 1'b1;
		return '0;
	end
	return x[31] ? 32'(-mag) : 32'(mag);
endfunction

// toward minus infinity, result rebuilt through itof
function automatic fp32_t model_floor(fp32_t x);
	int     e;
	int     drop;
	longint m;
	longint whole;
	e = int'(x[30:23]);
	if (e == 255 && x[22:0] != 0) return x | 32'h0040_0000;
	if (e >= 150) return x;
	if (e <= 126) return (x[31] && x[30:0] != 0) ? 32'hbf80_0000 : {x[31], 31'd0};
	drop  = 150 - e;	// bits below the binary point
	m     = longint'({1'b1, x[22:0]});
	whole = m >> drop;
	if (x[31] && (whole << drop) != m) whole++;
	return model_itof(x[31] ? 32'(-whole) : 32'(whole));
endfunction

function automatic void model_expect(instr_t i, fp32_t a, int32_t b,
		output fp32_t ey, output fpu_exc_t ee);
	ey = '0;
	ee = '0;
	if (i.op1 != OP1_COP1) ee.invalid_op = 1'b1;
	else if (i.fmt == FMT_S && i.op2 == FUNCT_ABS) ey = {1'b0, a[30:0]};
	else if (i.fmt == FMT_S && i.op2 == FUNCT_NEG) ey = {~a[31], a[30:0]};
	else if (i.fmt == FMT_S && i.op2 == FUNCT_FLOOR) ey = model_floor(a);
	else if (i.fmt == FMT_W_FTOI && i.op2 == FUNCT_CVT) ey = model_ftoi(a, ee);
	else if (i.fmt == FMT_ITOF && i.op2 == FUNCT_CVT) ey = model_itof(b);
	else ee.invalid_op = 1'b1;
endfunction

`endif

/* tests/fpu_tb.sv */
`default_nettype none

module fpu_tb import fpu_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 20;
	localparam int N_PER_TEST = 300;
	localparam int N_TESTS    = 6;
	// reset, prefill and a drain after every test
	localparam int TOTAL_INSTR = N_TESTS * (N_PER_TEST + LATENCY) + LATENCY + 3;

	logic     clk = 1'b0;
	logic     rstn;
	instr_t   instr;
	fp32_t    x1;
	int32_t   x2;
	fp32_t    y;
	fpu_exc_t exc;

	logic [31:0] rng_state;
	int          errors;
	int          checks;
	fp32_t       exp_y [$];
	fpu_exc_t    exp_exc [$];

	`include "fpu_model.svh"

	fpu_top dut (
		.clk   (clk),
		.rstn  (rstn),
		.instr (instr),
		.x1    (x1),
		.x2    (x2),
		.y     (y),
		.exc   (exc)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////
	// stimulus helpers

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// mostly edge exponents
	function automatic fp32_t rand_float();
		logic [31:0] r;
		logic [31:0] f;
		exp_t        e;
		r = next_rand();
		f = next_rand();
		case (r[2:0])
			3'd0:    e = 8'd0;
			3'd1:    e = 8'd126;
			3'd2:    e = 8'd127;
			3'd3:    e = 8'd150;
			3'd4:    e = 8'd158;
			3'd5:    e = EXP_MAX;
			3'd6:    e = EXP_BIAS + {3'd0, r[7:3]};	// integer range
			default: e = r[10:3];
		endcase
		return {r[31], e, (r[13:11] == 3'd0) ? 23'd0 : f[22:0]};
	endfunction

	function automatic int32_t rand_int();
		logic [31:0] r;
		logic [31:0] v;
		r = next_rand();
		v = next_rand();
		v = (32'd1 << r[6:2]) + {23'd0, v[8:0]};	// just above a power of two
		case (r[1:0])
			2'd0:    return next_rand();
			2'd1:    return v;
			2'd2:    return r[7] ? 32'h8000_0000 : 32'd0;
			default: return ~v + 32'd1;
		endcase
	endfunction

	function automatic fp32_t ftoi_edge(int j);
		case (j)
			0:       return 32'h3f00_0000;	// 0.5 up to 1
			1:       return 32'hbf00_0000;	// -0.5 down to -1
			2:       return 32'hcf00_0000;	// -2^31
			3:       return 32'h4f00_0000;	// 2^31 overflows
			4:       return 32'hbfc0_0000;	// -1.5
			default: return 32'h3eff_ffff;	// just under one half
		endcase
	endfunction

	function automatic instr_t op_instr(op_t op);
		case (op)
			OP_ABS:   return '{OP1_COP1, FMT_S, FUNCT_ABS};
			OP_NEG:   return '{OP1_COP1, FMT_S, FUNCT_NEG};
			OP_FLOOR: return '{OP1_COP1, FMT_S, FUNCT_FLOOR};
			OP_FTOI:  return '{OP1_COP1, FMT_W_FTOI, FUNCT_CVT};
			OP_ITOF:  return '{OP1_COP1, FMT_ITOF, FUNCT_CVT};
			default:  return '0;
		endcase
	endfunction

	////////////////////////////////////////
	// scoreboard

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	// oldest result is checked before the next instruction goes in
	task automatic step(input logic track, input instr_t i, input fp32_t a, input int32_t b);
		fp32_t    ey;
		fpu_exc_t ee;
		@(negedge clk);
		if (exp_y.size() == LATENCY || (!track && exp_y.size() != 0)) begin
			check_value("y", exp_y.pop_front(), y);
			check_value("exc", {29'd0, exp_exc.pop_front()}, {29'd0, exc});
		end
		instr = i;
		x1    = a;
		x2    = b;
		if (track) begin
			model_expect(i, a, b, ey, ee);
			exp_y.push_back(ey);
			exp_exc.push_back(ee);
		end
	endtask

	task automatic run_test(input string name, input int kind);
		int     errors_before;
		int     checks_before;
		instr_t i;
		fp32_t  a;
		int32_t b;
		logic [31:0] r;
		errors_before = errors;
		checks_before = checks;
		for (int j = 0; j < N_PER_TEST; j++) begin
			a = rand_float();
			b = rand_int();
			r = next_rand();
			case (kind)
				0: i = op_instr(op_t'(1 + r % 5));	// any valid op
				1: i = op_instr(r[0] ? OP_NEG : OP_ABS);
				2: i = op_instr(OP_FLOOR);
				3: begin
					i = op_instr(OP_FTOI);
					if (j < 6) a = ftoi_edge(j);
				end
				4: i = op_instr(OP_ITOF);
				default: begin
					i = r[16:0];	// random fields
					if (r[17]) i.op1 = OP1_COP1;
				end
			endcase
			step(1'b1, i, a, b);
		end
		repeat (LATENCY) step(1'b0, '0, '0, '0);	// drain
		$display("%s: %0d checks, %0d errors", name, checks - checks_before,
			errors - errors_before);
	endtask

	////////////////////////////////////////
	// test sequence

	initial begin
		fp32_t    ey;
		fpu_exc_t ee;
		rng_state = 32'h5cc2;
		errors    = 0;
		checks    = 0;
		rstn      = 1'b0;
		instr     = '0;
		x1        = '0;
		x2        = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;
		repeat (LATENCY - 1) begin	// stages cleared by reset
			exp_y.push_back('0);
			exp_exc.push_back('0);
		end
		// idle inputs are sampled once before the first step
		model_expect(instr, x1, x2, ey, ee);
		exp_y.push_back(ey);
		exp_exc.push_back(ee);
		run_test("pipeline order", 0);
		run_test("abs and neg", 1);
		run_test("floor", 2);
		run_test("ftoi", 3);
		run_test("itof", 4);
		run_test("invalid fields", 5);
		$display("%0d tests, %0d checks, %0d errors", N_TESTS, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		#((TOTAL_INSTR + 20) * CLK_PERIOD);
		$display("timeout, the test sequence did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/fpu_chk.sv */
`default_nettype none

module fpu_chk import fpu_pkg::*; (
	input wire           clk,
	input wire           rstn,
	input wire fp32_t    y,
	input wire fpu_exc_t exc
);
	timeunit 1ns;
	timeprecision 1ps;

	int cycles_out_of_reset;	// saturates at LATENCY

	always_ff @(posedge clk) begin
		if (!rstn) begin
			cycles_out_of_reset <= 0;
		end else if (cycles_out_of_reset < LATENCY) begin
			cycles_out_of_reset <= cycles_out_of_reset + 1;
		end
	end

	invalid_gives_zero: assert property (@(posedge clk) disable iff (!rstn)
		exc.invalid_op |-> y == '0)
		else $error("invalid_op raised with a nonzero result");

	nan_ovf_exclusive: assert property (@(posedge clk) disable iff (!rstn)
		!(exc.nan && exc.ovf))
		else $error("nan and ovf raised together");

	// pipeline still empty right after reset
	quiet_after_reset: assert property (@(posedge clk)
		(!rstn || cycles_out_of_reset < LATENCY - 1) |=> (y == '0 && exc == '0))
		else $error("outputs not zero during or right after reset");

endmodule

bind fpu_top fpu_chk u_chk (
	.clk  (clk),
	.rstn (rstn),
	.y    (y),
	.exc  (exc)
);

`default_nettype wire

/* verilog/fpu_top.sv */
`default_nettype none

module fpu_top import fpu_pkg::*; (
	input  wire         clk,
	input  wire         rstn,
	input  wire instr_t instr,
	input  wire fp32_t  x1,	// abs, neg, floor, ftoi
	input  wire int32_t x2,	// itof only
	output fp32_t       y,
	output fpu_exc_t    exc
);

	int32_t   ftoi_y;
	fpu_exc_t ftoi_flags;
	fp32_t    itof_y;
	fp32_t    floor_y;

	////////////////////////////////////////
	// conversion and rounding units

	fpu_ftoi u_ftoi (
		.clk   (clk),
		.rstn  (rstn),
		.x     (x1),
		.y     (ftoi_y),
		.flags (ftoi_flags)
	);

	fpu_itof u_itof (
		.clk  (clk),
		.rstn (rstn),
		.x    (x2),
		.y    (itof_y)
	);

	fpu_floor u_floor (
		.clk  (clk),
		.rstn (rstn),
		.x    (x1),
		.y    (floor_y)
	);

	// unit stage plus the output stages gives LATENCY
	fpu_result_select #(
		.OUT_STAGES (LATENCY - 1)
	) u_select (
		.clk        (clk),
		.rstn       (rstn),
		.instr      (instr),
		.x1         (x1),
		.ftoi_y     (ftoi_y),
		.ftoi_flags (ftoi_flags),
		.itof_y     (itof_y),
		.floor_y    (floor_y),
		.y          (y),
		.exc        (exc)
	);

endmodule

`default_nettype wire

/* verilog/fpu_result_select.sv */
`default_nettype none

module fpu_result_select import fpu_pkg::*; #(
	parameter int OUT_STAGES = 2
) (
	input  wire           clk,
	input  wire           rstn,
	input  wire instr_t   instr,
	input  wire fp32_t    x1,
	input  wire int32_t   ftoi_y,
	input  wire fpu_exc_t ftoi_flags,
	input  wire fp32_t    itof_y,
	input  wire fp32_t    floor_y,
	output fp32_t         y,
	output fpu_exc_t      exc
);

	typedef struct packed {
		fp32_t    y;
		fpu_exc_t exc;
	} result_t;

	op_t     op_d;
	op_t     op_q;
	fp32_t   sign_d;
	fp32_t   sign_q;
	result_t sel;
	result_t out_q [OUT_STAGES];

	function automatic op_t decode(instr_t i);
		op_t op;
		op = OP_INVALID;
		if (i.op1 == OP1_COP1) begin
			if (i.fmt == FMT_S) begin
				case (i.op2)
					FUNCT_ABS:   op = OP_ABS;
					FUNCT_NEG:   op = OP_NEG;
					FUNCT_FLOOR: op = OP_FLOOR;
					default:     op = OP_INVALID;
				endcase
			end else if (i.fmt == FMT_W_FTOI && i.op2 == FUNCT_CVT) begin
				op = OP_FTOI;
			end else if (i.fmt == FMT_ITOF && i.op2 == FUNCT_CVT) begin
				op = OP_ITOF;
			end
		end
		return op;
	endfunction

	////////////////////////////////////////
	// stage 1, decode and sign ops

	assign op_d = decode(instr);

	// abs unless it is a neg
	assign sign_d = (op_d == OP_NEG) ? {~x1[31], x1[30:0]} : {1'b0, x1[30:0]};

	always_ff @(posedge clk) begin
		if (!rstn) begin
			op_q   <= OP_IDLE;
			sign_q <= '0;
		end else begin
			op_q   <= op_d;
			sign_q <= sign_d;
		end
	end

	////////////////////////////////////////
	// stage 2, pick the unit result

	always_comb begin
		sel = '0;	// idle reads as zero
		case (op_q)
			OP_ABS, OP_NEG: sel.y = sign_q;
			OP_FLOOR:       sel.y = floor_y;
			OP_FTOI: begin
				sel.y   = ftoi_y;
				sel.exc = ftoi_flags;	// only unit with flags
			end
			OP_ITOF:        sel.y = itof_y;
			OP_INVALID:     sel.exc.invalid_op = 1'b1;
			default:        sel = '0;
		endcase
	end

	// first register takes the selection, the rest just delay it
	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 0; i < OUT_STAGES; i++) begin
				out_q[i] <= '0;
			end
		end else begin
			out_q[0] <= sel;
			for (int i = 1; i < OUT_STAGES; i++) begin
				out_q[i] <= out_q[i-1];
			end
		end
	end

	assign y   = out_q[OUT_STAGES-1].y;
	assign exc = out_q[OUT_STAGES-1].exc;

endmodule

`default_nettype wire

/* verilog/fpu_floor.sv */
`default_nettype none

module fpu_floor import fpu_pkg::*; (
	input  wire        clk,
	input  wire        rstn,
	input  wire fp32_t x,
	output fp32_t      y
);

	// from this exponent on there are no fractional bits left
	localparam exp_t EXP_INT = EXP_BIAS + 8'd23;

	exp_t        e;
	frac_t       frac;
	logic        is_nan;
	logic [4:0]  shamt;
	logic [45:0] aligned;
	logic        has_frac;
	logic [23:0] int_part;
	logic [46:0] restored;
	exp_t        e_out;
	fp32_t       y_d;

	assign e      = x[30:23];
	assign frac   = x[22:0];
	assign is_nan = (e == EXP_MAX) && (frac != '0);

	////////////////////////////////////////
	// 127 <= e < 150

	assign shamt = 5'(e - EXP_BIAS);	// at most 22 in range

	// integer part in [45:23], fraction below
	assign aligned  = {23'd1, frac} << shamt;
	assign has_frac = |aligned[22:0];

	// negative with a fraction rounds toward minus infinity
	assign int_part = {1'b0, aligned[45:23]} + {23'd0, x[31] & has_frac};

	// shift back; hidden bit at [23], carry at [24]
	assign restored = {int_part, 23'd0} >> shamt;
	assign e_out    = e + {7'd0, restored[24]};

	////////////////////////////////////////

	always_comb begin
		if (is_nan) begin
			y_d = {x[31], EXP_MAX, 1'b1, frac[21:0]};	// quiet it
		end else if (e >= EXP_INT) begin
			y_d = x;	// already integral or infinite
		end else if (e < EXP_BIAS) begin
			if (x[31] && x[30:0] != '0) begin
				y_d = {1'b1, EXP_BIAS, 23'd0};	// -1.0
			end else begin
				y_d = {x[31], 31'd0};
			end
		end else begin
			// a carry leaves [22:0] zero, no renormalizing shift needed
			y_d = {x[31], e_out, restored[22:0]};
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			y <= '0;
		end else begin
			y <= y_d;
		end
	end

endmodule

`default_nettype wire

/* verilog/fpu_itof.sv */
`default_nettype none

module fpu_itof import fpu_pkg::*; (
	input  wire         clk,
	input  wire         rstn,
	input  wire int32_t x,
	output fp32_t       y
);

	int32_t      mag;
	logic [4:0]  lead;
	logic [31:0] norm;
	sig_t        sig;
	logic        guard;
	logic        sticky;
	logic        round_up;
	logic [24:0] sum;
	exp_t        e;
	frac_t       frac;
	fp32_t       y_d;

	// -2^31 maps to 2^31, still right as unsigned
	assign mag = x[31] ? ~x + 32'd1 : x;

	////////////////////////////////////////
	// leading one search

	// highest set bit wins
	always_comb begin
		lead = '0;
		for (int i = 0; i < 32; i++) begin
			if (mag[i]) begin
				lead = 5'(i);
			end
		end
	end

	// leading one moved up to bit 31
	assign norm = mag << (5'd31 - lead);

	////////////////////////////////////////
	// round to nearest even

	assign sig      = norm[31:8];
	assign guard    = norm[7];
	assign sticky   = |norm[6:0];
	assign round_up = guard & (sig[0] | sticky);

	assign sum = {1'b0, sig} + {24'd0, round_up};	// carry in [24]

	// on carry the fraction is already all zeros
	assign frac = sum[22:0];
	assign e    = EXP_BIAS + {3'd0, lead} + {7'd0, sum[24]};

	assign y_d = (x == '0) ? '0 : {x[31], e, frac};	// zero gives +0

	always_ff @(posedge clk) begin
		if (!rstn) begin
			y <= '0;
		end else begin
			y <= y_d;
		end
	end

endmodule

`default_nettype wire

/* verilog/fpu_ftoi.sv */
`default_nettype none

module fpu_ftoi import fpu_pkg::*; (
	input  wire      clk,
	input  wire      rstn,
	input  wire fp32_t x,
	output int32_t   y,
	output fpu_exc_t flags
);

	localparam exp_t EXP_HALF    = EXP_BIAS - 8'd1;	// 0.5 <= |x| < 1
	localparam exp_t EXP_INT_TOP = EXP_BIAS + 8'd31;	// 2^31 <= |x| < 2^32

	exp_t        e;
	sig_t        sig;
	logic        is_nan;
	logic [55:0] aligned;
	logic [32:0] rounded;
	int32_t      y_d;
	fpu_exc_t    flags_d;

	assign e      = x[30:23];
	assign sig    = {1'b1, x[22:0]};	// denormals land below 126 anyway
	assign is_nan = (e == EXP_MAX) && (x[22:0] != '0);

	////////////////////////////////////////
	// place significand against the binary point

	// integer part ends up in [55:24], half bit in [23]
	always_comb begin
		if (e == EXP_HALF) begin
			aligned = {32'd0, sig};
		end else begin
			aligned = {31'd0, sig, 1'b0} << (e - EXP_BIAS);
		end
	end

	// half away from zero, done on the magnitude
	assign rounded = {1'b0, aligned[55:24]} + {32'd0, aligned[23]};

	always_comb begin
		y_d     = '0;
		flags_d = '0;
		if (is_nan) begin
			flags_d.nan = 1'b1;
		end else if (e > EXP_INT_TOP) begin
			flags_d.ovf = 1'b1;	// includes infinity
		end else if (e >= EXP_HALF) begin
			if (x[31] && rounded == {2'b01, 31'd0}) begin
				y_d = {1'b1, 31'd0};	// exactly -2^31 still fits
			end else if (rounded[32:31] != 2'b00) begin
				flags_d.ovf = 1'b1;
			end else if (x[31]) begin
				y_d = ~rounded[31:0] + 32'd1;
			end else begin
				y_d = rounded[31:0];
			end
		end
		// small magnitudes keep the zero default
	end

	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstn) begin
			y     <= '0;
			flags <= '0;
		end else begin
			y     <= y_d;
			flags <= flags_d;
		end
	end

endmodule

`default_nettype wire

/* verilog/fpu_pkg.sv */
`default_nettype none

package fpu_pkg;

	////////////////////////////////////////
	// ieee single precision fields

	typedef logic [31:0] fp32_t;	// raw single word
	typedef logic [31:0] int32_t;	// two's complement
	typedef logic [7:0]  exp_t;	// biased exponent
	typedef logic [22:0] frac_t;	// stored fraction
	typedef logic [23:0] sig_t;	// fraction with hidden bit

	localparam exp_t EXP_MAX  = 8'd255;
	localparam exp_t EXP_BIAS = 8'd127;

	// total cycles from issue to result
	localparam int LATENCY = 3;

	////////////////////////////////////////
	// instruction fields and encodings

	typedef struct packed {
		logic [5:0] op1;	// bits 31:26
		logic [4:0] fmt;	// bits 25:21
		logic [5:0] op2;	// bits 5:0
	} instr_t;

	typedef struct packed {
		logic invalid_op;
		logic nan;
		logic ovf;
	} fpu_exc_t;

	typedef enum logic [2:0] {
		OP_IDLE,
		OP_ABS,
		OP_NEG,
		OP_FLOOR,
		OP_FTOI,
		OP_ITOF,
		OP_INVALID
	} op_t;

	localparam logic [5:0] OP1_COP1    = 6'b010001;
	localparam logic [4:0] FMT_S       = 5'b10000;
	localparam logic [4:0] FMT_W_FTOI  = 5'b00000;
	localparam logic [4:0] FMT_ITOF    = 5'b00100;
	localparam logic [5:0] FUNCT_ABS   = 6'b000101;
	localparam logic [5:0] FUNCT_NEG   = 6'b000111;
	localparam logic [5:0] FUNCT_FLOOR = 6'b001111;
	localparam logic [5:0] FUNCT_CVT   = 6'b000000;

endpackage

`default_nettype wire
